// File: hw/lsu_cfg.svh
// load/store unit widths
// byte address, bus data and byte-enable widths shared by all blocks

`ifndef LSU_CFG_SVH
`define LSU_CFG_SVH

// byte address width of the core side and the data bus
`define LSU_ADDR_W 32

// data bus width
`define LSU_DATA_W 32

// one enable per data byte
`define LSU_BE_W (`LSU_DATA_W / 8)

`endif

// File: hw/lsu_pkg.sv
// load/store unit types
// access size and controller state encodings

package lsu_pkg;

  // access size as sent by the core, 2'b11 is handled as a byte
  typedef enum logic [1:0] {
    LSU_WORD = 2'b00,
    LSU_HALF = 2'b01,
    LSU_BYTE = 2'b10
  } lsu_type_e;

  // bus transaction FSM of the controller
  typedef enum logic [2:0] {
    IDLE,                      // no request in the address phase
    WAIT_GNT_MIS,              // first part of a split access waits for its grant
    WAIT_RVALID_MIS,           // first part granted, second part on the bus
    WAIT_GNT,                  // single or last part waits for its grant
    WAIT_RVALID_MIS_GNTS_DONE  // both parts granted, first response still due
  } ls_fsm_e;

endpackage

// File: hw/lsu_store_align.sv
// store aligner
// byte enables for each word part and write data rotated onto byte lanes

`include "lsu_cfg.svh"

module lsu_store_align (
  input  lsu_pkg::lsu_type_e      lsu_type_i,
  input  logic [1:0]              addr_offset_i,
  input  logic                    second_part_i,
  input  logic [`LSU_DATA_W-1:0]  lsu_wdata_i,
  output logic [`LSU_BE_W-1:0]    data_be_o,
  output logic [`LSU_DATA_W-1:0]  data_wdata_o
);

  import lsu_pkg::*;

  logic [`LSU_BE_W-1:0]     be_base;   // enables at offset zero
  logic [2*`LSU_BE_W-1:0]   be_span;   // enables over two adjacent words
  logic [2*`LSU_DATA_W-1:0] wdata_dbl; // doubled data for the rotation

  //////////////////////////////////////////////////
  // byte enables
  //////////////////////////////////////////////////

  always_comb begin
    unique case (lsu_type_i)
      LSU_WORD: be_base = 4'b1111;
      LSU_HALF: be_base = 4'b0011;
      default:  be_base = 4'b0001;  // byte, also for 2'b11
    endcase
  end

  // shifting into a two-word window lets the bytes past lane 3
  // fall into the upper half, which is what the second part writes
  assign be_span = {{`LSU_BE_W{1'b0}}, be_base} << addr_offset_i;

  always_comb begin
    if (second_part_i) begin
      data_be_o = be_span[2*`LSU_BE_W-1:`LSU_BE_W];  // low bytes of next word
    end else begin
      data_be_o = be_span[`LSU_BE_W-1:0];            // clipped at byte 3
    end
  end

  //////////////////////////////////////////////////
  // write data rotation
  //////////////////////////////////////////////////

  // rotate left by offset bytes, so byte n of the store sits on lane
  // (offset + n) mod 4 and both parts see the same lane mapping
  assign wdata_dbl    = {lsu_wdata_i, lsu_wdata_i} << {addr_offset_i, 3'b000};
  assign data_wdata_o = wdata_dbl[2*`LSU_DATA_W-1:`LSU_DATA_W];

endmodule

// File: hw/lsu_load_align.sv
// load aligner
// keeps the attributes of the running load and the upper bytes of a first
// part, then realigns and zero- or sign-extends the read data

`include "lsu_cfg.svh"

module lsu_load_align (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    txn_start_i,
  input  logic                    rdata_capture_i,
  input  lsu_pkg::lsu_type_e      lsu_type_i,
  input  logic                    lsu_sign_ext_i,
  input  logic [1:0]              addr_offset_i,
  input  logic [`LSU_DATA_W-1:0]  data_rdata_i,
  output logic [`LSU_DATA_W-1:0]  lsu_rdata_o
);

  import lsu_pkg::*;

  logic [1:0]              offset_q;
  lsu_type_e               type_q;
  logic                    sign_ext_q;
  logic [`LSU_DATA_W-1:8]  rdata_q;       // bytes 1..3 of the first word
  logic [`LSU_DATA_W-1:0]  rdata_merged;  // word assembled across two reads
  logic [`LSU_DATA_W-1:0]  rdata_shift;   // single word moved down to lane 0
  logic [15:0]             half_raw;
  logic [7:0]              byte_raw;

  //////////////////////////////////////////////////
  // transaction registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      offset_q   <= 2'b00;
      type_q     <= LSU_WORD;
      sign_ext_q <= 1'b0;
    end else if (txn_start_i) begin
      offset_q   <= addr_offset_i;
      type_q     <= lsu_type_i;
      sign_ext_q <= lsu_sign_ext_i;
    end
  end

  // byte 0 of the first word never belongs to a split load
  always_ff @(posedge clk_i) begin
    if (rdata_capture_i) begin
      rdata_q <= data_rdata_i[`LSU_DATA_W-1:8];
    end
  end

  //////////////////////////////////////////////////
  // realignment
  //////////////////////////////////////////////////

  always_comb begin
    unique case (offset_q)
      2'b01:   rdata_merged = {data_rdata_i[7:0],  rdata_q[31:8]};
      2'b10:   rdata_merged = {data_rdata_i[15:0], rdata_q[31:16]};
      2'b11:   rdata_merged = {data_rdata_i[23:0], rdata_q[31:24]};
      default: rdata_merged = data_rdata_i;  // aligned word
    endcase
  end

  assign rdata_shift = data_rdata_i >> {offset_q, 3'b000};

  // only a half at offset 3 spans two words
  assign half_raw = (offset_q == 2'b11) ? rdata_merged[15:0] : rdata_shift[15:0];
  assign byte_raw = rdata_shift[7:0];

  //////////////////////////////////////////////////
  // extension
  //////////////////////////////////////////////////

  always_comb begin
    unique case (type_q)
      LSU_WORD: lsu_rdata_o = rdata_merged;
      LSU_HALF: lsu_rdata_o = {{16{sign_ext_q & half_raw[15]}}, half_raw};
      default:  lsu_rdata_o = {{24{sign_ext_q & byte_raw[7]}}, byte_raw};
    endcase
  end

endmodule

// File: hw/lsu_ctrl.sv
// load/store transaction controller
// splits misaligned accesses into two word accesses, tracks grants
// and responses, forms the second word address and merges part errors

`include "lsu_cfg.svh"

module lsu_ctrl (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    lsu_req_valid_i,
  input  logic                    lsu_we_i,
  input  lsu_pkg::lsu_type_e      lsu_type_i,
  input  logic [`LSU_ADDR_W-1:0]  lsu_addr_i,
  input  logic                    data_gnt_i,
  input  logic                    data_rvalid_i,
  input  logic                    data_err_i,
  output logic                    lsu_req_ready_o,
  output logic                    data_req_o,
  output logic [`LSU_ADDR_W-1:0]  data_addr_o,
  output logic                    data_we_o,
  output logic                    second_part_o,
  output logic                    txn_start_o,
  output logic                    rdata_capture_o,
  output logic                    lsu_resp_valid_o,
  output logic                    lsu_resp_err_o,
  output logic                    busy_o
);

  import lsu_pkg::*;

  ls_fsm_e                  ls_fsm_cs, ls_fsm_ns;
  logic                     split_access;   // request needs two word accesses
  logic                     second_part_q, second_part_d;
  logic                     lsu_err_q, lsu_err_d;  // error of the first part
  logic                     first_rvalid;   // response of the first part arrives
  logic                     we_q;
  logic [`LSU_ADDR_W-1:2]   addr_q;         // word address of the first part
  logic [`LSU_ADDR_W-1:2]   addr_next;

  // word with nonzero offset, or half word crossing into the next word
  assign split_access = ((lsu_type_i == LSU_WORD) && (lsu_addr_i[1:0] != 2'b00)) ||
                        ((lsu_type_i == LSU_HALF) && (lsu_addr_i[1:0] == 2'b11));

  //////////////////////////////////////////////////
  // transaction FSM
  //////////////////////////////////////////////////

  always_comb begin
    ls_fsm_ns     = ls_fsm_cs;
    data_req_o    = 1'b0;
    second_part_d = second_part_q;
    lsu_err_d     = lsu_err_q;
    first_rvalid  = 1'b0;

    unique case (ls_fsm_cs)
      IDLE: begin
        if (lsu_req_valid_i) begin
          data_req_o = 1'b1;
          lsu_err_d  = 1'b0;  // fresh request
          if (data_gnt_i) begin
            second_part_d = split_access;
            ls_fsm_ns     = split_access ? WAIT_RVALID_MIS : IDLE;
          end else begin
            ls_fsm_ns     = split_access ? WAIT_GNT_MIS : WAIT_GNT;
          end
        end
      end

      WAIT_GNT_MIS: begin
        data_req_o = 1'b1;  // hold first part
        if (data_gnt_i) begin
          second_part_d = 1'b1;
          ls_fsm_ns     = WAIT_RVALID_MIS;
        end
      end

      WAIT_RVALID_MIS: begin
        data_req_o = 1'b1;  // second part goes out while the first is in flight
        if (data_rvalid_i) begin
          first_rvalid  = 1'b1;
          lsu_err_d     = data_err_i;
          second_part_d = ~data_gnt_i;
          ls_fsm_ns     = data_gnt_i ? IDLE : WAIT_GNT;
        end else if (data_gnt_i) begin
          // both granted, first response still outstanding
          second_part_d = 1'b0;
          ls_fsm_ns     = WAIT_RVALID_MIS_GNTS_DONE;
        end
      end

      WAIT_GNT: begin
        data_req_o = 1'b1;
        if (data_gnt_i) begin
          second_part_d = 1'b0;
          ls_fsm_ns     = IDLE;  // last response arrives in IDLE
        end
      end

      WAIT_RVALID_MIS_GNTS_DONE: begin
        if (data_rvalid_i) begin
          first_rvalid = 1'b1;
          lsu_err_d    = data_err_i;
          ls_fsm_ns    = IDLE;
        end
      end

      default: begin
        ls_fsm_ns = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ls_fsm_cs     <= IDLE;
      second_part_q <= 1'b0;
      lsu_err_q     <= 1'b0;
    end else begin
      ls_fsm_cs     <= ls_fsm_ns;
      second_part_q <= second_part_d;
      lsu_err_q     <= lsu_err_d;
    end
  end

  //////////////////////////////////////////////////
  // first-part attributes
  //////////////////////////////////////////////////

  // first grant of a request, aligned or first part
  assign txn_start_o = data_req_o & data_gnt_i & ~second_part_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      we_q <= 1'b0;
    end else if (txn_start_o) begin
      we_q <= lsu_we_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (txn_start_o) begin
      addr_q <= lsu_addr_i[`LSU_ADDR_W-1:2];
    end
  end

  assign addr_next = addr_q + 1'b1;  // next word

  //////////////////////////////////////////////////
  // outputs
  //////////////////////////////////////////////////

  assign data_addr_o = second_part_q ? {addr_next, 2'b00}
                                     : {lsu_addr_i[`LSU_ADDR_W-1:2], 2'b00};
  assign data_we_o   = lsu_we_i;  // held by the core until the last grant

  // final grant, either unsplit or the second part
  assign lsu_req_ready_o = data_req_o & data_gnt_i & (second_part_q | ~split_access);

  assign second_part_o   = second_part_q;
  assign rdata_capture_o = first_rvalid & ~we_q;  // loads only

  assign lsu_resp_valid_o = data_rvalid_i & (ls_fsm_cs == IDLE);
  assign lsu_resp_err_o   = lsu_resp_valid_o & (lsu_err_q | data_err_i);
  assign busy_o           = (ls_fsm_cs != IDLE);

endmodule

// File: hw/lsu_top.sv
// load/store unit top
// joins the transaction controller with the store and load aligners

`include "lsu_cfg.svh"

module lsu_top (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  // core request
  input  logic                    lsu_req_valid_i,
  input  logic                    lsu_we_i,
  input  lsu_pkg::lsu_type_e      lsu_type_i,
  input  logic                    lsu_sign_ext_i,
  input  logic [`LSU_ADDR_W-1:0]  lsu_addr_i,
  input  logic [`LSU_DATA_W-1:0]  lsu_wdata_i,
  output logic                    lsu_req_ready_o,
  // core response
  output logic                    lsu_resp_valid_o,
  output logic                    lsu_resp_err_o,
  output logic [`LSU_DATA_W-1:0]  lsu_rdata_o,
  output logic                    busy_o,
  // data bus
  output logic                    data_req_o,
  input  logic                    data_gnt_i,
  input  logic                    data_rvalid_i,
  input  logic                    data_err_i,
  output logic [`LSU_ADDR_W-1:0]  data_addr_o,
  output logic                    data_we_o,
  output logic [`LSU_BE_W-1:0]    data_be_o,
  output logic [`LSU_DATA_W-1:0]  data_wdata_o,
  input  logic [`LSU_DATA_W-1:0]  data_rdata_i
);

  logic       second_part;    // second word of a split access on the bus
  logic       txn_start;      // first grant of a request
  logic       rdata_capture;  // first-part read data valid on the bus
  logic [1:0] addr_offset;    // byte offset inside the word

  assign addr_offset = lsu_addr_i[1:0];

  lsu_ctrl ctrl_i (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .lsu_req_valid_i  (lsu_req_valid_i),
    .lsu_we_i         (lsu_we_i),
    .lsu_type_i       (lsu_type_i),
    .lsu_addr_i       (lsu_addr_i),
    .data_gnt_i       (data_gnt_i),
    .data_rvalid_i    (data_rvalid_i),
    .data_err_i       (data_err_i),
    .lsu_req_ready_o  (lsu_req_ready_o),
    .data_req_o       (data_req_o),
    .data_addr_o      (data_addr_o),
    .data_we_o        (data_we_o),
    .second_part_o    (second_part),
    .txn_start_o      (txn_start),
    .rdata_capture_o  (rdata_capture),
    .lsu_resp_valid_o (lsu_resp_valid_o),
    .lsu_resp_err_o   (lsu_resp_err_o),
    .busy_o           (busy_o)
  );

  lsu_store_align store_align_i (
    .lsu_type_i    (lsu_type_i),
    .addr_offset_i (addr_offset),
    .second_part_i (second_part),
    .lsu_wdata_i   (lsu_wdata_i),
    .data_be_o     (data_be_o),
    .data_wdata_o  (data_wdata_o)
  );

  lsu_load_align load_align_i (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .txn_start_i     (txn_start),
    .rdata_capture_i (rdata_capture),
    .lsu_type_i      (lsu_type_i),
    .lsu_sign_ext_i  (lsu_sign_ext_i),
    .addr_offset_i   (addr_offset),
    .data_rdata_i    (data_rdata_i),
    .lsu_rdata_o     (lsu_rdata_o)
  );

endmodule

// File: bench/tb_lsu_mem.sv
// bus memory model for the load/store unit
// 64 words, random grant and response delays, in-order responses and
// an error on one selected word address

`include "lsu_cfg.svh"

module tb_lsu_mem (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    data_req_i,
  output logic                    data_gnt_o,
  output logic                    data_rvalid_o,
  output logic                    data_err_o,
  input  logic [`LSU_ADDR_W-1:0]  data_addr_i,
  input  logic                    data_we_i,
  input  logic [`LSU_BE_W-1:0]    data_be_i,
  input  logic [`LSU_DATA_W-1:0]  data_wdata_i,
  output logic [`LSU_DATA_W-1:0]  data_rdata_o,
  input  logic                    err_en_i,    // fault accesses to err_addr_i
  input  logic [`LSU_ADDR_W-1:0]  err_addr_i
);

  timeunit 1ns;
  timeprecision 1ps;

  localparam int         WORDS = 64;
  localparam logic [7:0] FILL  = 8'hA5;  // xor'ed with each byte address
  localparam logic [7:0] SEED  = 8'd50;

  logic [7:0]  mem [WORDS*4];
  logic [7:0]  lfsr = SEED;
  logic [1:0]  gnt_wait;                  // cycles left before the next grant
  int          cycle;                     // index of the current cycle
  int          due_q [$];                 // cycle of each pending rvalid
  logic [31:0] rdata_q [$];
  logic        err_q [$];

  // 8-bit Fibonacci LFSR, taps 8 6 5 4
  function automatic logic [7:0] lfsr_next(input logic [7:0] s);
    return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
  endfunction

  // one step per bit taken
  task automatic draw_bits(output logic [1:0] bits);
    bits = 2'b00;
    for (int i = 0; i < 2; i++) begin
      lfsr = lfsr_next(lfsr);
      bits = {bits[0], lfsr[0]};
    end
  endtask

  initial begin
    for (int a = 0; a < WORDS * 4; a++) begin
      mem[a] = a[7:0] ^ FILL;
    end
  end

  assign data_gnt_o = data_req_i && (gnt_wait == 2'd0);

  //////////////////////////////////////////////////
  // accept, write, queue response
  //////////////////////////////////////////////////

  always @(posedge clk_i or negedge rst_ni) begin
    logic [1:0]  bits;
    logic [7:0]  base;
    logic        hit;
    if (!rst_ni) begin
      gnt_wait      <= 2'd0;
      data_rvalid_o <= 1'b0;
      data_err_o    <= 1'b0;
      data_rdata_o  <= '0;
      cycle = 0;
    end else begin
      cycle = cycle + 1;  // the grant below happened in cycle - 1
      if (data_req_i && data_gnt_o) begin
        base = {data_addr_i[7:2], 2'b00};
        hit  = err_en_i && (data_addr_i[31:2] == err_addr_i[31:2]);
        rdata_q.push_back({mem[base+3], mem[base+2], mem[base+1], mem[base]});
        err_q.push_back(hit);
        if (data_we_i && !hit) begin  // a faulted store leaves the word alone
          for (int b = 0; b < 4; b++) begin
            if (data_be_i[b]) begin
              mem[base+b] = data_wdata_i[8*b +: 8];
            end
          end
        end
        draw_bits(bits);
        due_q.push_back(cycle + int'(bits) % 3);  // 1 to 3 cycles after grant
        draw_bits(bits);
        gnt_wait <= bits;  // 0 to 3 cycles for the next request
      end else if (data_req_i) begin
        gnt_wait <= gnt_wait - 2'd1;
      end
      if (due_q.size() > 0 && due_q[0] <= cycle) begin
        data_rvalid_o <= 1'b1;
        data_rdata_o  <= rdata_q.pop_front();
        data_err_o    <= err_q.pop_front();
        void'(due_q.pop_front());
      end else begin
        data_rvalid_o <= 1'b0;
        data_err_o    <= 1'b0;
      end
    end
  end

endmodule

// File: bench/tb_lsu.sv
// load/store unit testbench
// replays bench/lsu_tests.txt on the DUT and checks grants, response
// pulses, error flags and load data of every access

`include "lsu_cfg.svh"

module tb_lsu;

  timeunit 1ns;
  timeprecision 1ps;

  import lsu_pkg::*;

  localparam int HALF_PERIOD = 4;   // 8 ns clock
  localparam int RST_CYCLES  = 16;
  localparam int WAIT_LIMIT  = 20;  // cycles allowed per handshake
  localparam int TEST_CYCLES = 40;  // watchdog budget per test line

  logic                    clk_i = 1'b0;
  logic                    rst_ni;
  logic                    req_valid, we, sign_ext, req_ready;
  lsu_type_e               lsu_type;
  logic [`LSU_ADDR_W-1:0]  addr, data_addr, err_addr;
  logic [`LSU_DATA_W-1:0]  wdata, rdata, data_wdata, data_rdata;
  logic                    resp_valid, resp_err, busy;
  logic                    data_req, data_gnt, data_rvalid, data_err, data_we;
  logic [`LSU_BE_W-1:0]    data_be;
  logic                    err_en;
  int                      n_tests = 0;
  int                      n_pass = 0;
  int                      n_fail = 0;

  always #HALF_PERIOD clk_i = ~clk_i;

  lsu_top lsu_top_i (
    .clk_i (clk_i), .rst_ni (rst_ni),
    .lsu_req_valid_i (req_valid), .lsu_we_i (we), .lsu_type_i (lsu_type),
    .lsu_sign_ext_i (sign_ext), .lsu_addr_i (addr), .lsu_wdata_i (wdata),
    .lsu_req_ready_o (req_ready), .lsu_resp_valid_o (resp_valid),
    .lsu_resp_err_o (resp_err), .lsu_rdata_o (rdata), .busy_o (busy),
    .data_req_o (data_req), .data_gnt_i (data_gnt), .data_rvalid_i (data_rvalid),
    .data_err_i (data_err), .data_addr_o (data_addr), .data_we_o (data_we),
    .data_be_o (data_be), .data_wdata_o (data_wdata), .data_rdata_i (data_rdata)
  );

  tb_lsu_mem mem_i (
    .clk_i (clk_i), .rst_ni (rst_ni),
    .data_req_i (data_req), .data_gnt_o (data_gnt), .data_rvalid_o (data_rvalid),
    .data_err_o (data_err), .data_addr_i (data_addr), .data_we_i (data_we),
    .data_be_i (data_be), .data_wdata_i (data_wdata), .data_rdata_o (data_rdata),
    .err_en_i (err_en), .err_addr_i (err_addr)
  );

  // a word off its boundary, or a half in the last byte, takes two bus words
  function automatic int grants_needed(input int type_v, input logic [1:0] offset);
    if (type_v == 0 && offset != 2'd0) begin
      return 2;
    end
    if (type_v == 1 && offset == 2'd3) begin
      return 2;
    end
    return 1;
  endfunction

  //////////////////////////////////////////////////
  // one test line from request to idle cycle
  //////////////////////////////////////////////////

  task automatic run_test(input string line, input int idx);
    string       op_s;
    string       err_s;
    int          type_v;
    int          sign_v;
    int          exp_err;
    logic [31:0] addr_v;
    logic [31:0] wdata_v;
    logic [31:0] exp_rdata;
    int          grants;
    int          pulses;
    int          waited;
    bit          ready_seen;
    bit          busy_seen;
    bit          ok;
    ok         = 1'b1;
    grants     = 0;
    pulses     = 0;
    waited     = 0;
    ready_seen = 1'b0;
    busy_seen  = 1'b0;
    void'($sscanf(line, "%s %d %d %h %h %s %d %h", op_s, type_v, sign_v, addr_v,
                  wdata_v, err_s, exp_err, exp_rdata));
    @(posedge clk_i);
    req_valid <= 1'b1;
    we        <= (op_s == "st");
    lsu_type  <= lsu_type_e'(type_v[1:0]);
    sign_ext  <= sign_v[0];
    addr      <= addr_v;
    wdata     <= wdata_v;
    err_en    <= (err_s != "none");
    err_addr  <= err_s.atohex();  // none reads as zero
    // address phase sampled mid-cycle
    while (!ready_seen && waited < WAIT_LIMIT) begin
      @(negedge clk_i);
      waited++;
      grants += int'(data_req && data_gnt);
      pulses += int'(resp_valid);
      busy_seen = busy_seen | busy;  // a split stays out of idle between its grants
      ready_seen = req_ready;
    end
    @(posedge clk_i);
    req_valid <= 1'b0;  // taken at this edge
    waited = 0;
    while (pulses == 0 && waited < WAIT_LIMIT) begin
      @(negedge clk_i);
      waited++;
      if (resp_valid) begin
        pulses++;
        if (resp_err !== exp_err[0]) begin
          $display("error lsu_resp_err_o: got %h, expected %h", resp_err, exp_err[0]);
          ok = 1'b0;
        end
        if (op_s == "ld" && exp_err == 0 && rdata !== exp_rdata) begin
          $display("error lsu_rdata_o: got %h, expected %h", rdata, exp_rdata);
          ok = 1'b0;
        end
      end
    end
    @(negedge clk_i);  // one idle cycle
    pulses += int'(resp_valid);
    if (!ready_seen) begin
      $display("test %0d: request never accepted within %0d cycles", idx, WAIT_LIMIT);
      ok = 1'b0;
    end else if (grants != grants_needed(type_v, addr_v[1:0])) begin
      $display("test %0d: saw %0d bus grants instead of %0d", idx, grants,
               grants_needed(type_v, addr_v[1:0]));
      ok = 1'b0;
    end else if (grants_needed(type_v, addr_v[1:0]) == 2 && !busy_seen) begin
      $display("test %0d: busy never rose during a split access", idx);
      ok = 1'b0;
    end
    if (pulses == 0) begin
      $display("test %0d: no response arrived within %0d cycles", idx, WAIT_LIMIT);
      ok = 1'b0;
    end else if (pulses != 1) begin
      $display("test %0d: %0d response pulses for one request", idx, pulses);
      ok = 1'b0;
    end
    if (data_req || busy) begin
      $display("test %0d: bus request or busy still high after the response", idx);
      ok = 1'b0;
    end
    $display("test %0d: %s type %0d at %h %s", idx, op_s, type_v, addr_v,
             ok ? "ok" : "FAILED");
    if (ok) begin
      n_pass++;
    end else begin
      n_fail++;
    end
  endtask

  //////////////////////////////////////////////////
  // main sequence and watchdog
  //////////////////////////////////////////////////

  initial begin : main
    int    fd;
    string line;
    string lines [$];
    rst_ni    = 1'b0;
    req_valid = 1'b0;
    we        = 1'b0;
    lsu_type  = LSU_WORD;
    sign_ext  = 1'b0;
    addr      = '0;
    wdata     = '0;
    err_en    = 1'b0;
    err_addr  = '0;
    fd = $fopen("bench/lsu_tests.txt", "r");
    if (fd == 0) begin
      $display("could not open bench/lsu_tests.txt");
      n_fail++;
    end else begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() > 1 && line.getc(0) != "#") begin
          lines.push_back(line);  // header lines skipped
        end
      end
      $fclose(fd);
    end
    n_tests = lines.size();
    repeat (RST_CYCLES) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    if (data_req || resp_valid || busy) begin
      $display("bus request, response or busy high right after reset");
      n_fail++;
    end
    foreach (lines[i]) begin
      run_test(lines[i], i + 1);
    end
    $display("tests: %0d, passed: %0d, failed: %0d", n_tests, n_pass, n_fail);
    if (n_fail == 0 && n_tests > 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin : watchdog
    wait (n_tests > 0);
    repeat (RST_CYCLES + n_tests * TEST_CYCLES) @(posedge clk_i);
    $display("timeout, the tests did not finish in %0d cycles", n_tests * TEST_CYCLES);
    $display("Simulation failed");
    $finish;
  end

endmodule

// File: list.f
+incdir+hw
hw/lsu_pkg.sv
hw/lsu_store_align.sv
hw/lsu_load_align.sv
hw/lsu_ctrl.sv
hw/lsu_top.sv
bench/tb_lsu_mem.sv
bench/tb_lsu.sv

// File: Bender.yml
package:
  name: lsu

sources:
  - include_dirs:
      - hw
    files:
      - hw/lsu_pkg.sv
      - hw/lsu_store_align.sv
      - hw/lsu_load_align.sv
      - hw/lsu_ctrl.sv
      - hw/lsu_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - bench/tb_lsu_mem.sv
      - bench/tb_lsu.sv

// File: bench/lsu_tests.txt
# op type sign addr wdata err_word exp_err exp_rdata
# type 0 word, 1 half, 2 byte; err_word is the faulting word address or none
ld 0 0 00000000 00000000 none 0 a6a7a4a5
ld 1 1 00000002 00000000 none 0 ffffa6a7
ld 1 0 00000004 00000000 none 0 0000a0a1
ld 2 1 00000083 00000000 none 0 00000026
ld 2 1 00000005 00000000 none 0 ffffffa0
ld 2 0 00000006 00000000 none 0 000000a3
ld 1 1 00000086 00000000 none 0 00002223
ld 0 0 00000009 00000000 none 0 a9aeafac
ld 0 0 0000000e 00000000 none 0 b4b5aaab
ld 0 1 00000013 00000000 none 0 b3b0b1b6
ld 1 1 00000017 00000000 none 0 ffffbdb2
ld 1 0 0000008b 00000000 none 0 0000292e
st 0 0 00000020 11223344 none 0 00000000
ld 0 0 00000020 00000000 none 0 11223344
st 0 0 00000026 55667788 none 0 00000000
ld 0 0 00000024 00000000 none 0 77888081
ld 0 0 00000028 00000000 none 0 8e8f5566
st 1 0 00000023 0000beef none 0 00000000
st 2 0 00000021 000000c3 none 0 00000000
ld 0 0 00000021 00000000 none 0 beef22c3
ld 0 0 00000040 00000000 00000040 1 00000000
ld 0 0 00000042 00000000 00000044 1 00000000
ld 1 0 00000043 00000000 00000040 1 00000000
st 0 0 00000051 aabbccdd 00000054 1 00000000
ld 0 0 00000050 00000000 none 0 bbccddf5
ld 0 0 00000054 00000000 none 0 f2f3f0f1
st 2 0 00000062 0000005a 00000060 1 00000000
ld 2 1 00000062 00000000 none 0 ffffffc7
